// ==== hw/decode_params.svh ====
// slot format widths and field positions, included by the decoder packages and RTL
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// word and group widths
`define INSTR_WORD_W 32
`define FETCH_W 96

// lane-side widths
`define REG_ID_W 6
`define IMM_W 33

// slot-side field widths
`define REG_FIELD_W 5
`define IMM_FIELD_W 11
`define OPC_W 6

// all ones here marks a valid op
`define OP_MARK_HI 31
`define OP_MARK_LO 29

`define PRED_BIT 28
`define WEX_BIT 27
`define OPC_HI 26
`define OPC_LO 21
`define RN_HI 20
`define RN_LO 16
`define RM_HI 15
`define RM_LO 11
`define RO_HI 10
`define RO_LO 6

// immediate shares its low bits with ro
`define IMM_HI 10
`define IMM_LO 0

`endif

// ==== hw/instrPkg.sv ====
// encoding types of a single instruction, imported by the slot decoder and lane logic
`include "decode_params.svh"

package instrPkg;

	typedef logic [`REG_ID_W-1:0] regIdT;
	typedef logic signed [`IMM_W-1:0] immT;

	// null register, idle lanes point here
	localparam regIdT REG_ZZR = regIdT'(63);

	typedef enum logic [`OPC_W-1:0]
	{
		NOP   = 6'd0,
		ADD   = 6'd1,
		SUB   = 6'd2,
		AND   = 6'd3,
		OR    = 6'd4,
		CMPQ  = 6'd5,
		MOVI  = 6'd6,
		ADDI  = 6'd7,
		ADDX  = 6'd8,
		MOVX  = 6'd9,
		CMPX  = 6'd10,
		INVOP = 6'd63
	} opcodeE;

	// forms that take the 11-bit immediate
	function automatic logic isImmForm(opcodeE opc);
		return (opc == MOVI) || (opc == ADDI);
	endfunction

	// 128-bit ops, split over an even/odd pair when scalar
	function automatic logic isWideOp(opcodeE opc);
		return (opc == ADDX) || (opc == MOVX) || (opc == CMPX);
	endfunction

endpackage

// ==== hw/bundlePkg.sv ====
// bundle-level types shared by lane steering, pairing and the output stage
package bundlePkg;

	localparam int LANE_COUNT = 3;

	// encoded value is the number of words taken
	typedef enum logic [1:0]
	{
		WIDTH_ONE   = 2'd1,
		WIDTH_TWO   = 2'd2,
		WIDTH_THREE = 2'd3
	} bundleWidthE;

endpackage

// ==== hw/slotDecoder.sv ====
// decodes one 32-bit slot word into opcode, register ids, immediate and bundle flags
`include "decode_params.svh"

module slotDecoder
(
	input  logic [`INSTR_WORD_W-1:0] word,
	output instrPkg::opcodeE         opcode,
	output instrPkg::regIdT          rn,
	output instrPkg::regIdT          rm,
	output instrPkg::regIdT          ro,
	output instrPkg::immT            imm,
	output logic                     pred,
	output logic                     isOp,
	output logic                     wex
);
	import instrPkg::*;

	logic [`OPC_W-1:0]       opcField;
	logic [`REG_FIELD_W-1:0] rnField;
	logic [`REG_FIELD_W-1:0] rmField;
	logic [`REG_FIELD_W-1:0] roField;
	logic [`IMM_FIELD_W-1:0] immField;
	opcodeE                  fieldOpc;

	assign opcField = word[`OPC_HI:`OPC_LO];
	assign rnField  = word[`RN_HI:`RN_LO];
	assign rmField  = word[`RM_HI:`RM_LO];
	assign roField  = word[`RO_HI:`RO_LO];
	assign immField = word[`IMM_HI:`IMM_LO];

	assign isOp = &word[`OP_MARK_HI:`OP_MARK_LO];
	assign pred = word[`PRED_BIT];
	assign wex  = isOp && word[`WEX_BIT];  // a non-op never continues

	// values outside the opcode set fall back to INVOP
	always_comb
	begin
		case (opcField)
			NOP, ADD, SUB, AND, OR, CMPQ, MOVI, ADDI, ADDX, MOVX, CMPX, INVOP:
				fieldOpc = opcodeE'(opcField);
			default:
				fieldOpc = INVOP;
		endcase
	end

	always_comb
	begin
		opcode = INVOP;
		rn     = regIdT'(0);
		rm     = regIdT'(0);
		ro     = regIdT'(0);
		imm    = immT'(0);
		if (isOp)
		begin
			opcode = fieldOpc;
			rn     = regIdT'(rnField);  // zero-extended
			rm     = regIdT'(rmField);
			if (isImmForm(fieldOpc))
			begin
				ro  = REG_ZZR;  // ro bits belong to the immediate
				imm = {{(`IMM_W-`IMM_FIELD_W){immField[`IMM_FIELD_W-1]}}, immField};
			end
			else
				ro = regIdT'(roField);
		end
	end

endmodule

// ==== hw/laneSteering.sv ====
// picks the bundle width and routes slot decodes onto lanes A, B and C in reverse order
module laneSteering
(
	input  logic                   wexEnable,
	input  instrPkg::opcodeE       s0Opcode,
	input  instrPkg::regIdT        s0Rn, s0Rm, s0Ro,
	input  instrPkg::immT          s0Imm,
	input  logic                   s0Pred, s0IsOp, s0Wex,
	input  instrPkg::opcodeE       s1Opcode,
	input  instrPkg::regIdT        s1Rn, s1Rm, s1Ro,
	input  instrPkg::immT          s1Imm,
	input  logic                   s1Pred, s1IsOp, s1Wex,
	input  instrPkg::opcodeE       s2Opcode,
	input  instrPkg::regIdT        s2Rn, s2Rm, s2Ro,
	input  instrPkg::immT          s2Imm,
	input  logic                   s2Pred, s2IsOp, s2Wex,
	output instrPkg::opcodeE       opcodeA, opcodeB, opcodeC,
	output instrPkg::regIdT        rnA, rmA, roA,
	output instrPkg::regIdT        rnB, rmB, roB,
	output instrPkg::regIdT        rnC, rmC, roC,
	output instrPkg::immT          immA, immB, immC,
	output logic                   predA, predB, predC,
	output bundlePkg::bundleWidthE bundleWidth
);
	import instrPkg::*;
	import bundlePkg::*;

	localparam logic [1:0] IDLE_SRC = 2'(LANE_COUNT);

	// one entry per slot plus the idle lane at the end
	opcodeE slotOpc  [LANE_COUNT+1];
	regIdT  slotRn   [LANE_COUNT+1];
	regIdT  slotRm   [LANE_COUNT+1];
	regIdT  slotRo   [LANE_COUNT+1];
	immT    slotImm  [LANE_COUNT+1];
	logic   slotPred [LANE_COUNT+1];
	logic [1:0] contSlot;
	logic [1:0] srcA;
	logic [1:0] srcB;
	logic [1:0] srcC;

	assign slotOpc  = '{s0Opcode, s1Opcode, s2Opcode, NOP};
	assign slotRn   = '{s0Rn, s1Rn, s2Rn, REG_ZZR};
	assign slotRm   = '{s0Rm, s1Rm, s2Rm, REG_ZZR};
	assign slotRo   = '{s0Ro, s1Ro, s2Ro, REG_ZZR};
	assign slotImm  = '{s0Imm, s1Imm, s2Imm, immT'(0)};
	assign slotPred = '{s0Pred, s1Pred, s2Pred, 1'b0};

	// predicated ops always close the bundle
	assign contSlot = {s1IsOp && s1Wex && !s1Pred,
		s0IsOp && s0Wex && !s0Pred} & {2{wexEnable}};

	always_comb
	begin
		if (contSlot[0] && contSlot[1])
		begin
			bundleWidth = WIDTH_THREE;
			srcA        = 2'd2;
			srcB        = 2'd1;
			srcC        = 2'd0;
		end
		else if (contSlot[0])
		begin
			bundleWidth = WIDTH_TWO;
			srcA        = 2'd1;
			srcB        = 2'd0;
			srcC        = IDLE_SRC;
		end
		else
		begin
			bundleWidth = WIDTH_ONE;
			srcA        = 2'd0;
			srcB        = IDLE_SRC;
			srcC        = IDLE_SRC;
		end

		opcodeA = slotOpc[srcA];
		rnA     = slotRn[srcA];
		rmA     = slotRm[srcA];
		roA     = slotRo[srcA];
		immA    = slotImm[srcA];
		predA   = slotPred[srcA];
		opcodeB = slotOpc[srcB];
		rnB     = slotRn[srcB];
		rmB     = slotRm[srcB];
		roB     = slotRo[srcB];
		immB    = slotImm[srcB];
		predB   = slotPred[srcB];
		opcodeC = slotOpc[srcC];
		rnC     = slotRn[srcC];
		rmC     = slotRm[srcC];
		roC     = slotRo[srcC];
		immC    = slotImm[srcC];
		predC   = slotPred[srcC];

		// lane C only carries an op in a three-word bundle
		if (bundleWidth != WIDTH_THREE)
			assert (opcodeC == NOP);
	end

endmodule

// ==== hw/dualLanePairing.sv ====
// rewrites lanes A and B of a scalar wide op as an even/odd register pair
`include "decode_params.svh"

module dualLanePairing
(
	input  bundlePkg::bundleWidthE bundleWidth,
	input  instrPkg::opcodeE       opcodeAIn, opcodeBIn,
	input  instrPkg::regIdT        rnAIn, rmAIn, roAIn,
	input  instrPkg::regIdT        rnBIn, rmBIn, roBIn,
	input  instrPkg::immT          immAIn, immBIn,
	input  logic                   predAIn, predBIn,
	output instrPkg::opcodeE       opcodeAOut, opcodeBOut,
	output instrPkg::regIdT        rnAOut, rmAOut, roAOut,
	output instrPkg::regIdT        rnBOut, rmBOut, roBOut,
	output instrPkg::immT          immAOut, immBOut,
	output logic                   predAOut, predBOut
);
	import instrPkg::*;
	import bundlePkg::*;

	logic  pairOp;
	logic  swapBit;
	regIdT pairRn;
	regIdT pairRm;
	regIdT pairRo;

	// low field bit moves to the top, swap bit picks the half
	function automatic regIdT pairId(regIdT field, logic swap);
		return {field[0], field[`REG_FIELD_W-1:1], swap};
	endfunction

	assign pairOp  = (bundleWidth == WIDTH_ONE) && isWideOp(opcodeAIn);
	assign swapBit = (opcodeAIn == CMPX);  // compare reads the pair high half first

	assign pairRn = pairId(rnAIn, swapBit);
	assign pairRm = pairId(rmAIn, swapBit);
	assign pairRo = pairId(roAIn, swapBit);

	always_comb
	begin
		opcodeAOut = opcodeAIn;
		rnAOut     = rnAIn;
		rmAOut     = rmAIn;
		roAOut     = roAIn;
		immAOut    = immAIn;
		predAOut   = predAIn;
		opcodeBOut = opcodeBIn;
		rnBOut     = rnBIn;
		rmBOut     = rmBIn;
		roBOut     = roBIn;
		immBOut    = immBIn;
		predBOut   = predBIn;
		if (pairOp)
		begin
			rnAOut     = pairRn;
			rmAOut     = pairRm;
			roAOut     = pairRo;
			// lane B runs the other half of the pair
			opcodeBOut = opcodeAIn;
			rnBOut     = pairRn ^ regIdT'(1);
			rmBOut     = pairRm ^ regIdT'(1);
			roBOut     = pairRo ^ regIdT'(1);
			immBOut    = immAIn;
			predBOut   = predAIn;
		end
	end

endmodule

// ==== hw/decodeStage.sv ====
// one-entry registered output stage with a valid/ready handshake for a decoded bundle
module decodeStage
(
	input  logic                   clock,
	input  logic                   arstN,
	input  logic                   inValid,
	output logic                   inReady,
	output logic                   outValid,
	input  logic                   outReady,
	input  instrPkg::opcodeE       opcodeAIn, opcodeBIn, opcodeCIn,
	input  instrPkg::regIdT        rnAIn, rmAIn, roAIn,
	input  instrPkg::regIdT        rnBIn, rmBIn, roBIn,
	input  instrPkg::regIdT        rnCIn, rmCIn, roCIn,
	input  instrPkg::immT          immAIn, immBIn, immCIn,
	input  logic                   predAIn, predBIn, predCIn,
	input  bundlePkg::bundleWidthE bundleWidthIn,
	output instrPkg::opcodeE       opcodeA, opcodeB, opcodeC,
	output instrPkg::regIdT        rnA, rmA, roA,
	output instrPkg::regIdT        rnB, rmB, roB,
	output instrPkg::regIdT        rnC, rmC, roC,
	output instrPkg::immT          immA, immB, immC,
	output logic                   predA, predB, predC,
	output bundlePkg::bundleWidthE bundleWidth
);

	logic load;

	assign inReady = !outValid || outReady;  // refill in the cycle the entry leaves
	assign load    = inValid && inReady;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			opcodeA     <= opcodeAIn;
			rnA         <= rnAIn;
			rmA         <= rmAIn;
			roA         <= roAIn;
			immA        <= immAIn;
			predA       <= predAIn;
			opcodeB     <= opcodeBIn;
			rnB         <= rnBIn;
			rmB         <= rmBIn;
			roB         <= roBIn;
			immB        <= immBIn;
			predB       <= predBIn;
			opcodeC     <= opcodeCIn;
			rnC         <= rnCIn;
			rmC         <= rmCIn;
			roC         <= roCIn;
			immC        <= immCIn;
			predC       <= predCIn;
			bundleWidth <= bundleWidthIn;
		end
	end

	// a stalled bundle stays put until the consumer takes it
	stallHold: assert property (@(posedge clock) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable({opcodeA, rnA, rmA, roA, immA, predA,
			opcodeB, rnB, rmB, roB, immB, predB,
			opcodeC, rnC, rmC, roC, immC, predC, bundleWidth}));

	resetIdle: assert property (@(posedge clock) !arstN |-> !outValid);

endmodule

// ==== hw/bundleDecoder.sv ====
// bundle decoder top, slices the fetch group and chains slot decode, steering, pairing, stage
`include "decode_params.svh"

module bundleDecoder
(
	input  logic                   clock,
	input  logic                   arstN,
	input  logic [`FETCH_W-1:0]    fetchWord,
	input  logic                   wexEnable,
	input  logic                   inValid,
	output logic                   inReady,
	output logic                   outValid,
	input  logic                   outReady,
	output instrPkg::opcodeE       opcodeA, opcodeB, opcodeC,
	output instrPkg::regIdT        rnA, rmA, roA,
	output instrPkg::regIdT        rnB, rmB, roB,
	output instrPkg::regIdT        rnC, rmC, roC,
	output instrPkg::immT          immA, immB, immC,
	output logic                   predA, predB, predC,
	output bundlePkg::bundleWidthE bundleWidth
);
	import instrPkg::*;
	import bundlePkg::*;

	logic [`INSTR_WORD_W-1:0] slotWord [LANE_COUNT];

	// per-slot decodes
	opcodeE sOpc   [LANE_COUNT];
	regIdT  sRn    [LANE_COUNT];
	regIdT  sRm    [LANE_COUNT];
	regIdT  sRo    [LANE_COUNT];
	immT    sImm   [LANE_COUNT];
	logic   sPred  [LANE_COUNT];
	logic   sIsOp  [LANE_COUNT];
	logic   sWex   [LANE_COUNT];

	// steered lanes
	opcodeE      stOpcA, stOpcB, stOpcC;
	regIdT       stRnA, stRmA, stRoA, stRnB, stRmB, stRoB, stRnC, stRmC, stRoC;
	immT         stImmA, stImmB, stImmC;
	logic        stPredA, stPredB, stPredC;
	bundleWidthE stWidth;

	// lanes A and B after pairing
	opcodeE pOpcA, pOpcB;
	regIdT  pRnA, pRmA, pRoA, pRnB, pRmB, pRoB;
	immT    pImmA, pImmB;
	logic   pPredA, pPredB;

	always_comb
	begin
		for (int i = 0; i < LANE_COUNT; i++)
			slotWord[i] = fetchWord[i*`INSTR_WORD_W +: `INSTR_WORD_W];  // slot 0 is lowest
	end

	slotDecoder slot0I (.word(slotWord[0]), .opcode(sOpc[0]), .rn(sRn[0]), .rm(sRm[0]),
		.ro(sRo[0]), .imm(sImm[0]), .pred(sPred[0]), .isOp(sIsOp[0]), .wex(sWex[0]));

	slotDecoder slot1I (.word(slotWord[1]), .opcode(sOpc[1]), .rn(sRn[1]), .rm(sRm[1]),
		.ro(sRo[1]), .imm(sImm[1]), .pred(sPred[1]), .isOp(sIsOp[1]), .wex(sWex[1]));

	slotDecoder slot2I (.word(slotWord[2]), .opcode(sOpc[2]), .rn(sRn[2]), .rm(sRm[2]),
		.ro(sRo[2]), .imm(sImm[2]), .pred(sPred[2]), .isOp(sIsOp[2]), .wex(sWex[2]));

	laneSteering steerI
	(
		.wexEnable(wexEnable),
		.s0Opcode(sOpc[0]), .s0Rn(sRn[0]), .s0Rm(sRm[0]), .s0Ro(sRo[0]), .s0Imm(sImm[0]),
		.s0Pred(sPred[0]), .s0IsOp(sIsOp[0]), .s0Wex(sWex[0]),
		.s1Opcode(sOpc[1]), .s1Rn(sRn[1]), .s1Rm(sRm[1]), .s1Ro(sRo[1]), .s1Imm(sImm[1]),
		.s1Pred(sPred[1]), .s1IsOp(sIsOp[1]), .s1Wex(sWex[1]),
		.s2Opcode(sOpc[2]), .s2Rn(sRn[2]), .s2Rm(sRm[2]), .s2Ro(sRo[2]), .s2Imm(sImm[2]),
		.s2Pred(sPred[2]), .s2IsOp(sIsOp[2]), .s2Wex(sWex[2]),
		.opcodeA(stOpcA), .opcodeB(stOpcB), .opcodeC(stOpcC),
		.rnA(stRnA), .rmA(stRmA), .roA(stRoA),
		.rnB(stRnB), .rmB(stRmB), .roB(stRoB),
		.rnC(stRnC), .rmC(stRmC), .roC(stRoC),
		.immA(stImmA), .immB(stImmB), .immC(stImmC),
		.predA(stPredA), .predB(stPredB), .predC(stPredC),
		.bundleWidth(stWidth)
	);

	dualLanePairing pairI
	(
		.bundleWidth(stWidth),
		.opcodeAIn(stOpcA), .opcodeBIn(stOpcB),
		.rnAIn(stRnA), .rmAIn(stRmA), .roAIn(stRoA),
		.rnBIn(stRnB), .rmBIn(stRmB), .roBIn(stRoB),
		.immAIn(stImmA), .immBIn(stImmB), .predAIn(stPredA), .predBIn(stPredB),
		.opcodeAOut(pOpcA), .opcodeBOut(pOpcB),
		.rnAOut(pRnA), .rmAOut(pRmA), .roAOut(pRoA),
		.rnBOut(pRnB), .rmBOut(pRmB), .roBOut(pRoB),
		.immAOut(pImmA), .immBOut(pImmB), .predAOut(pPredA), .predBOut(pPredB)
	);

	// lane C bypasses pairing
	decodeStage stageI
	(
		.clock(clock), .arstN(arstN),
		.inValid(inValid), .inReady(inReady), .outValid(outValid), .outReady(outReady),
		.opcodeAIn(pOpcA), .opcodeBIn(pOpcB), .opcodeCIn(stOpcC),
		.rnAIn(pRnA), .rmAIn(pRmA), .roAIn(pRoA),
		.rnBIn(pRnB), .rmBIn(pRmB), .roBIn(pRoB),
		.rnCIn(stRnC), .rmCIn(stRmC), .roCIn(stRoC),
		.immAIn(pImmA), .immBIn(pImmB), .immCIn(stImmC),
		.predAIn(pPredA), .predBIn(pPredB), .predCIn(stPredC),
		.bundleWidthIn(stWidth),
		.opcodeA(opcodeA), .opcodeB(opcodeB), .opcodeC(opcodeC),
		.rnA(rnA), .rmA(rmA), .roA(roA),
		.rnB(rnB), .rmB(rmB), .roB(roB),
		.rnC(rnC), .rmC(rmC), .roC(roC),
		.immA(immA), .immB(immB), .immC(immC),
		.predA(predA), .predB(predB), .predC(predC),
		.bundleWidth(bundleWidth)
	);

endmodule

// ==== test/bundleModel.svh ====
// reference model of the bundle decoder, included inside the testbench module body
`ifndef BUNDLE_MODEL_SVH
`define BUNDLE_MODEL_SVH

typedef struct packed
{
	opcodeE opc;
	regIdT  rn;
	regIdT  rm;
	regIdT  ro;
	immT    imm;
	logic   pred;
} laneT;

// lanes[0] is lane A
typedef struct packed
{
	laneT [2:0]  lanes;
	bundleWidthE width;
} expBundleT;

function automatic laneT idleLane();
	laneT l;
	l = '0;
	l.opc = NOP;
	l.rn = REG_ZZR;
	l.rm = REG_ZZR;
	l.ro = REG_ZZR;
	return l;
endfunction

// one slot word as it lands on a lane
function automatic laneT slotModel(logic [31:0] w);
	laneT l;
	logic [5:0] f;
	l = '0;
	l.opc = INVOP;
	l.pred = w[28];
	f = w[26:21];
	if (w[31:29] == 3'b111)
	begin
		l.opc = ((f <= 6'd10) || (f == 6'd63)) ? opcodeE'(f) : INVOP;
		l.rn = {1'b0, w[20:16]};
		l.rm = {1'b0, w[15:11]};
		if (l.opc == MOVI || l.opc == ADDI)
		begin
			l.ro = REG_ZZR;
			l.imm = {{22{w[10]}}, w[10:0]};
		end
		else
			l.ro = {1'b0, w[10:6]};
	end
	return l;
endfunction

function automatic logic continues(logic [31:0] w, logic wexEn);
	return wexEn && (w[31:29] == 3'b111) && w[27] && !w[28];
endfunction

// even/odd pair id of a 5-bit register field
function automatic regIdT pairOf(logic [4:0] f, logic swap);
	return {f[0], f[4:1], swap};
endfunction

function automatic expBundleT modelBundle(logic [95:0] group, logic wexEn);
	expBundleT e;
	laneT s0;
	laneT s1;
	laneT s2;
	logic swap;
	s0 = slotModel(group[31:0]);
	s1 = slotModel(group[63:32]);
	s2 = slotModel(group[95:64]);
	if (continues(group[31:0], wexEn) && continues(group[63:32], wexEn))
	begin
		e.width = WIDTH_THREE;
		e.lanes[0] = s2;
		e.lanes[1] = s1;
		e.lanes[2] = s0;
	end
	else if (continues(group[31:0], wexEn))
	begin
		e.width = WIDTH_TWO;
		e.lanes[0] = s1;
		e.lanes[1] = s0;
		e.lanes[2] = idleLane();
	end
	else
	begin
		e.width = WIDTH_ONE;
		e.lanes[0] = s0;
		e.lanes[1] = idleLane();
		e.lanes[2] = idleLane();
	end
	if (e.width == WIDTH_ONE && (e.lanes[0].opc inside {ADDX, MOVX, CMPX}))
	begin
		swap = (e.lanes[0].opc == CMPX);
		e.lanes[0].rn = pairOf(e.lanes[0].rn[4:0], swap);
		e.lanes[0].rm = pairOf(e.lanes[0].rm[4:0], swap);
		e.lanes[0].ro = pairOf(e.lanes[0].ro[4:0], swap);
		e.lanes[1] = e.lanes[0];  // odd half, same op
		e.lanes[1].rn = {e.lanes[0].rn[5:1], ~e.lanes[0].rn[0]};
		e.lanes[1].rm = {e.lanes[0].rm[5:1], ~e.lanes[0].rm[0]};
		e.lanes[1].ro = {e.lanes[0].ro[5:1], ~e.lanes[0].ro[0]};
	end
	return e;
endfunction

`endif

// ==== test/bundleDecoderTb.sv ====
// testbench that drives directed and random fetch groups into the bundle decoder and scores the lanes
`include "decode_params.svh"

module bundleDecoderTb;
	import instrPkg::*;
	import bundlePkg::*;

	`include "bundleModel.svh"

	localparam int GROUP_COUNT  = 400;
	localparam int ACCEPT_LIMIT = 200;
	localparam int DRAIN_LIMIT  = 50;
	localparam logic [5:0] KNOWN_OPC [12] = '{6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd5,
		6'd6, 6'd7, 6'd8, 6'd9, 6'd10, 6'd63};

	logic                clock;
	logic                arstN;
	logic [`FETCH_W-1:0] fetchWord;
	logic                wexEnable;
	logic                inValid;
	logic                inReady;
	logic                outValid;
	logic                outReady;
	opcodeE              opcodeA, opcodeB, opcodeC;
	regIdT               rnA, rmA, roA, rnB, rmB, roB, rnC, rmC, roC;
	immT                 immA, immB, immC;
	logic                predA, predB, predC;
	bundleWidthE         bundleWidth;

	logic [31:0] rngState;
	int          mismatchCount = 0;
	int          otherErrors = 0;
	expBundleT   expQueue [$];
	expBundleT   heldBundle;
	expBundleT   popped;
	logic        acceptedLast = 1'b0;
	logic        stalledLast = 1'b0;
	string       laneNames [3] = '{"A", "B", "C"};

	bundleDecoder dut_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic logic likelyHigh();  // three in four
		logic [31:0] r;
		r = nextRand();
		return r[31:30] != 2'd0;
	endfunction

	// mostly valid ops from the known set and now and then junk
	function automatic logic [31:0] randomSlot();
		logic [31:0] r;
		logic [31:0] f;
		logic [2:0]  marker;
		logic [5:0]  opc;
		r = nextRand();
		f = nextRand();
		marker = (r[31:29] != 3'd0) ? 3'b111 : r[28:26];
		opc = (r[25:24] != 2'd0) ? KNOWN_OPC[r[23:20] % 4'd12] : r[19:14];
		return {marker, r[13] & r[12], r[11] | r[10], opc, f[31:11]};
	endfunction

	function automatic logic [31:0] packSlot(logic pred, logic wex, opcodeE opc,
		logic [4:0] rn, logic [4:0] rm, logic [10:0] low);
		return {3'b111, pred, wex, opc, rn, rm, low};
	endfunction

	function automatic expBundleT gatherOutputs();
		expBundleT g;
		g.lanes[0] = '{opcodeA, rnA, rmA, roA, immA, predA};
		g.lanes[1] = '{opcodeB, rnB, rmB, roB, immB, predB};
		g.lanes[2] = '{opcodeC, rnC, rmC, roC, immC, predC};
		g.width = bundleWidth;
		return g;
	endfunction

	task automatic reportError(string msg);
		otherErrors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic finishRun();
		$display("Closing report: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic checkOpcode(string name, opcodeE got, opcodeE exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic checkReg(string name, regIdT got, regIdT exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkImm(string name, immT got, immT exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkWidth(string name, bundleWidthE got, bundleWidthE exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compareBundle(expBundleT e);
		expBundleT got;
		got = gatherOutputs();
		for (int i = 0; i < LANE_COUNT; i++)
		begin
			checkOpcode({"opcode", laneNames[i]}, got.lanes[i].opc, e.lanes[i].opc);
			checkReg({"rn", laneNames[i]}, got.lanes[i].rn, e.lanes[i].rn);
			checkReg({"rm", laneNames[i]}, got.lanes[i].rm, e.lanes[i].rm);
			checkReg({"ro", laneNames[i]}, got.lanes[i].ro, e.lanes[i].ro);
			checkImm({"imm", laneNames[i]}, got.lanes[i].imm, e.lanes[i].imm);
			checkBit({"pred", laneNames[i]}, got.lanes[i].pred, e.lanes[i].pred);
		end
		checkWidth("bundleWidth", got.width, e.width);
	endtask

	// scoreboard samples values before the edge updates them
	always @(posedge clock)
	begin
		if (arstN)
		begin
			// the stage is empty exactly when no accepted bundle is outstanding
			checkBit("inReady", inReady, expQueue.size() == 0 || outReady);
			if (acceptedLast && !outValid)
				reportError("accepted bundle did not show up one cycle later");
			if (stalledLast && (!outValid || gatherOutputs() !== heldBundle))
				reportError("outputs changed while stalled by outReady");
			if (outValid && outReady)
			begin
				if (expQueue.size() == 0)
					reportError("output transfer with no bundle outstanding");
				else
				begin
					popped = expQueue.pop_front();
					compareBundle(popped);
				end
			end
			if (inValid && inReady)
				expQueue.push_back(modelBundle(fetchWord, wexEnable));
			acceptedLast = inValid && inReady;
			stalledLast  = outValid && !outReady;
			heldBundle   = gatherOutputs();
		end
	end

	task automatic idleCycle();
		@(posedge clock);
		@(negedge clock);
		outReady = likelyHigh();
	endtask

	// holds the group until accepted while outReady toggles
	task automatic sendGroup(logic [`FETCH_W-1:0] group, logic wexEn);
		int   waitCount;
		logic accepted;
		fetchWord = group;
		wexEnable = wexEn;
		inValid   = 1'b1;
		waitCount = 0;
		accepted  = 1'b0;
		while (!accepted)
		begin
			@(posedge clock);
			accepted = inReady;
			@(negedge clock);
			outReady = likelyHigh();
			waitCount++;
			if (!accepted && waitCount > ACCEPT_LIMIT)
			begin
				reportError("timed out waiting for a fetch group to be accepted");
				finishRun();
			end
		end
		inValid = 1'b0;
	endtask

	initial
	begin
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		int          waitCount;
		rngState  = 32'hb257;
		arstN     = 1'b0;
		fetchWord = '0;
		wexEnable = 1'b0;
		inValid   = 1'b0;
		outReady  = 1'b0;
		repeat (3)
		begin
			@(negedge clock);
			if (outValid)
				reportError("outValid high during reset");
		end
		arstN = 1'b1;

		sendGroup({32'h0, 32'h0, packSlot(0, 0, MOVI, 5'd3, 5'd4, 11'h7f0)}, 1'b1);
		sendGroup({32'h0, 32'h0, packSlot(0, 0, ADDI, 5'd9, 5'd1, 11'h123)}, 1'b1);
		w0 = packSlot(0, 1, ADD, 5'd1, 5'd2, 11'h0c0);
		w1 = packSlot(0, 1, SUB, 5'd5, 5'd6, 11'h1c0);
		w2 = packSlot(0, 0, ADDX, 5'd11, 5'd12, 11'h340);
		sendGroup({w2, w1, w0}, 1'b1);  // width three keeps the wide op unpaired
		sendGroup({w2, w1, w0}, 1'b0);
		sendGroup({w2, w1, packSlot(1, 1, OR, 5'd7, 5'd8, 11'h240)}, 1'b1);
		sendGroup({w2, w1, packSlot(0, 0, CMPX, 5'd7, 5'd12, 11'h540)}, 1'b1);
		sendGroup({w2, w1, packSlot(0, 0, MOVX, 5'd30, 5'd17, 11'h7c0)}, 1'b1);
		sendGroup({w2, w1, 32'h1234_5678}, 1'b1);  // not an op
		sendGroup({w2, w1, 3'b111, 2'b01, 6'd33, 21'h0abcd}, 1'b1);

		for (int n = 0; n < GROUP_COUNT; n++)
		begin
			w0 = randomSlot();
			w1 = randomSlot();
			w2 = randomSlot();
			sendGroup({w2, w1, w0}, likelyHigh());
			if (!likelyHigh())
				idleCycle();
		end

		waitCount = 0;
		while ((expQueue.size() != 0 || outValid) && waitCount < DRAIN_LIMIT)
		begin
			@(negedge clock);
			outReady = 1'b1;
			waitCount++;
		end
		if (expQueue.size() != 0 || outValid)
			reportError("timed out waiting for the outstanding bundles to drain");
		finishRun();
	end

endmodule

// ==== verilog.f ====
+incdir+hw
+incdir+test
hw/instrPkg.sv
hw/bundlePkg.sv
hw/slotDecoder.sv
hw/laneSteering.sv
hw/dualLanePairing.sv
hw/decodeStage.sv
hw/bundleDecoder.sv
test/bundleDecoderTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bundle decoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module bundleDecoderTb -f verilog.f -o bundleSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/bundleSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
